// File: all.f
+incdir+test
verilog/dispatch_pkg.sv
verilog/instr_decoder.sv
verilog/reg_status_table.sv
verilog/dispatch_stage.sv
verilog/fu_slot.sv
verilog/wb_arbiter.sv
verilog/dispatch_core_top.sv
test/tb_dispatch_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_dispatch_core -o tb_dispatch_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dispatch_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    exit 0
fi
echo "simulation reported failures"
exit 1

// File: test/scoreboard_model.svh
`ifndef SCOREBOARD_MODEL_SVH
`define SCOREBOARD_MODEL_SVH

// what the model needs to know about one instruction word
typedef struct packed {
    logic        has_fu;
    fu_id_t      id;
    logic        s_wr;
    logic        m_wr;
    logic        load;
    logic [11:0] imm;
} op_info_t;

// a register is pending while its tag is not ready
tag_t exp_s_tag [N_SREGS];
tag_t exp_m_tag [N_MREGS];
logic [N_FU-1:0] slot_busy;
int slot_cnt [N_FU];
wb_t slot_dest [N_FU];
int rr_ptr;
issue_t exp_issue;

function automatic op_info_t decode_op(input logic [31:0] w);
    // field order is has_fu, id, s_wr, m_wr, load, imm
    case (w[6:0])
        OP_ALU:    return '{1'b1, FU_ALU, 1'b1, 1'b0, 1'b0, 12'd0};
        OP_ALUI:   return '{1'b1, FU_ALU, 1'b1, 1'b0, 1'b0, w[31:20]};
        OP_LOAD:   return '{1'b1, FU_LDST, 1'b1, 1'b0, 1'b1, w[31:20]};
        OP_STORE:  return '{1'b1, FU_LDST, 1'b0, 1'b0, 1'b0, {w[31:25], w[11:7]}};
        OP_BRANCH: return '{1'b1, FU_BRANCH, 1'b0, 1'b0, 1'b0,
                            {w[31], w[7], w[30:25], w[11:8]}};
        OP_MLOAD:  return '{1'b1, FU_MLDST, 1'b0, 1'b1, 1'b1, {{9{w[14]}}, w[14:12]}};
        OP_MSTORE: return '{1'b1, FU_MLDST, 1'b0, 1'b0, 1'b0, {{9{w[14]}}, w[14:12]}};
        OP_GEMM:   return '{1'b1, FU_GEMM, 1'b0, 1'b1, 1'b0, 12'd0};
        // nop and unused opcodes reach no unit
        default:   return '{1'b0, FU_ALU, 1'b0, 1'b0, 1'b0, 12'd0};
    endcase
endfunction

task automatic reset_model();
    for (int i = 0; i < N_SREGS; i++) begin
        exp_s_tag[i] = TAG_READY;
    end
    for (int i = 0; i < N_MREGS; i++) begin
        exp_m_tag[i] = TAG_READY;
    end
    for (int i = 0; i < N_FU; i++) begin
        slot_cnt[i] = 0;
        slot_dest[i] = '0;
    end
    slot_busy = '0;
    rr_ptr = 0;
    exp_issue = '0;
endtask

// checks the current cycle and steps the model across the next rising edge
task automatic predict_cycle(output logic accepted);
    op_info_t d;
    logic hazard;
    logic found;
    int win;
    int idx;
    d = decode_op(instr);
    hazard = d.has_fu && slot_busy[d.id];
    if (d.s_wr) begin
        hazard = hazard || (exp_s_tag[instr[11:7]] != TAG_READY);
    end else if (d.m_wr) begin
        hazard = hazard || (exp_m_tag[instr[31:28]] != TAG_READY);
    end
    compare_value("stall", 64'(hazard), 64'(stall));

    // first slot past its latency when searching from the pointer
    found = 1'b0;
    win = 0;
    for (int i = 0; i < N_FU; i++) begin
        idx = (rr_ptr + i) % N_FU;
        if (!found && slot_busy[idx] && slot_cnt[idx] == 0) begin
            found = 1'b1;
            win = idx;
        end
    end
    compare_value("wb.valid", 64'(found), 64'(wb.valid));
    if (found && wb.valid) begin
        compare_value("wb.fu_id", 64'(win), 64'(wb.fu_id));
        compare_value("wb.s_rw_en", 64'(slot_dest[win].s_rw_en), 64'(wb.s_rw_en));
        compare_value("wb.m_rw_en", 64'(slot_dest[win].m_rw_en), 64'(wb.m_rw_en));
        if (slot_dest[win].s_rw_en) begin
            compare_value("wb.s_rw", 64'(slot_dest[win].s_rw), 64'(wb.s_rw));
        end
        if (slot_dest[win].m_rw_en) begin
            compare_value("wb.m_rw", 64'(slot_dest[win].m_rw), 64'(wb.m_rw));
        end
    end

    accepted = fetch_valid && !hazard && !freeze && !flush;

    // operand tags of the issue record are taken before this edge's updates
    if (flush) begin
        exp_issue = '0;
    end else if (!freeze) begin
        exp_issue = '0;
        if (accepted && d.has_fu) begin
            exp_issue.valid = 1'b1;
            exp_issue.fu_id = d.id;
            exp_issue.s_rd = instr[11:7];
            exp_issue.m_rd = instr[31:28];
            exp_issue.rs1 = instr[19:15];
            exp_issue.rs2 = instr[24:20];
            exp_issue.ms1 = instr[27:24];
            exp_issue.ms2 = instr[23:20];
            exp_issue.ms3 = instr[19:16];
            exp_issue.imm = d.imm;
            // gemm reads three matrix operands and the rest read two scalar ones
            if (d.id == FU_GEMM) begin
                exp_issue.t1 = exp_m_tag[instr[27:24]];
                exp_issue.t2 = exp_m_tag[instr[23:20]];
                exp_issue.t3 = exp_m_tag[instr[19:16]];
            end else begin
                exp_issue.t1 = exp_s_tag[instr[19:15]];
                exp_issue.t2 = exp_s_tag[instr[24:20]];
            end
        end
    end

    if (found) begin
        if (slot_dest[win].s_rw_en) begin
            exp_s_tag[slot_dest[win].s_rw] = TAG_READY;
        end
        if (slot_dest[win].m_rw_en) begin
            exp_m_tag[slot_dest[win].m_rw] = TAG_READY;
        end
        slot_busy[win] = 1'b0;
        rr_ptr = (win + 1) % N_FU;
    end
    for (int i = 0; i < N_FU; i++) begin
        if (slot_busy[i] && slot_cnt[i] != 0) begin
            slot_cnt[i]--;
        end
    end

    if (accepted && d.has_fu) begin
        slot_busy[d.id] = 1'b1;
        slot_cnt[d.id] = FU_LAT[d.id];
        slot_dest[d.id] = '0;
        slot_dest[d.id].fu_id = d.id;
        slot_dest[d.id].s_rw_en = d.s_wr;
        slot_dest[d.id].s_rw = instr[11:7];
        slot_dest[d.id].m_rw_en = d.m_wr;
        slot_dest[d.id].m_rw = instr[31:28];
        if (d.s_wr) begin
            exp_s_tag[instr[11:7]] = d.load ? TAG_LOAD : TAG_EXEC;
        end
        if (d.m_wr) begin
            exp_m_tag[instr[31:28]] = d.load ? TAG_LOAD : TAG_EXEC;
        end
    end
endtask

`endif

// File: test/tb_dispatch_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch_core;
    import dispatch_pkg::*;

    localparam int N_INSTR = 400;
    localparam int CLK_PERIOD = 20;
    localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
    localparam int WATCHDOG_NS = N_INSTR * (LAT_GEMM + N_FU + 4) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'hd9b8_5ba2;

    // repeats set the opcode weights and the last entry is an unused opcode
    localparam logic [6:0] OP_MIX [16] = '{
        OP_ALU, OP_ALU, OP_ALU, OP_ALUI, OP_ALUI, OP_LOAD, OP_LOAD, OP_STORE,
        OP_BRANCH, OP_MLOAD, OP_MLOAD, OP_MSTORE, OP_GEMM, OP_GEMM, OP_NOP, 7'h7f
    };

    logic CLK;
    logic nRST;
    logic fetch_valid;
    logic [WORD_W-1:0] instr;
    logic freeze;
    logic flush;
    logic stall;
    issue_t issue;
    wb_t wb;
    int checks;
    int errors;

    dispatch_core_top dut0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .fetch_valid(fetch_valid),
        .instr      (instr),
        .freeze     (freeze),
        .flush      (flush),
        .stall      (stall),
        .issue      (issue),
        .wb         (wb)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error at time %0t: %s expected 'h%0h got 'h%0h", $time, name, exp, got);
        end
    endtask

    task automatic check_condition(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("failure at time %0t: %s", $time, what);
        end
    endtask

    `include "scoreboard_model.svh"

    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        w = $urandom;
        w[6:0] = OP_MIX[$urandom % 16];
        // few registers in use so that hazards come often
        w[11:7] = 5'($urandom % 4);
        w[19:15] = 5'($urandom % 4);
        w[24:20] = 5'($urandom % 4);
        w[31:28] = 4'($urandom % 4);
        if (w[6:0] == OP_GEMM) begin
            w[27:24] = 4'($urandom % 4);
            w[23:20] = 4'($urandom % 4);
            w[19:16] = 4'($urandom % 4);
        end
        return w;
    endfunction

    task automatic run_cycle(input logic valid_in, input logic [31:0] word, input logic frz,
                             input logic fls, output logic accepted);
        @(negedge CLK);
        // issue register has settled after the last rising edge
        if (exp_issue.valid) begin
            compare_value("issue", 64'(exp_issue), 64'(issue));
        end else begin
            compare_value("issue.valid", 64'(1'b0), 64'(issue.valid));
        end
        fetch_valid = valid_in;
        instr = word;
        freeze = frz;
        flush = fls;
        #(SAMPLE_DELAY);
        predict_cycle(accepted);
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %s finished with %0d errors", name, errors - mark);
    endtask

    initial begin
        int seed_ret;
        int n_acc;
        int mark;
        logic acc;
        logic v;
        logic frz;
        logic fls;
        logic [31:0] word;
        seed_ret = $urandom(SEED);
        CLK = 1'b0;
        nRST = 1'b0;
        fetch_valid = 1'b0;
        instr = '0;
        freeze = 1'b0;
        flush = 1'b0;
        checks = 0;
        errors = 0;
        reset_model();
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // fetch holds the word until it is accepted
        mark = errors;
        n_acc = 0;
        word = random_instr();
        while (n_acc < N_INSTR) begin
            v = ($urandom % 10) != 0;
            frz = ($urandom % 100) < 5;
            fls = ($urandom % 100) < 3;
            run_cycle(v, word, frz, fls, acc);
            if (acc) begin
                n_acc++;
                word = random_instr();
            end
        end
        report_test("random stream", mark);

        mark = errors;
        while (slot_busy != '0) begin
            run_cycle(1'b0, '0, 1'b0, 1'b0, acc);
        end
        run_cycle(1'b0, '0, 1'b0, 1'b0, acc);
        report_test("drain", mark);

        // together these read or write every register that the stream used
        mark = errors;
        run_cycle(1'b1, {7'd0, 5'd2, 5'd1, 3'd0, 5'd3, OP_ALU}, 1'b0, 1'b0, acc);
        check_condition(acc && !stall, "dependent scalar instruction was not dispatched");
        run_cycle(1'b1, {4'd3, 4'd0, 4'd1, 4'd2, 9'd0, OP_GEMM}, 1'b0, 1'b0, acc);
        check_condition(acc && !stall, "dependent matrix instruction was not dispatched");
        run_cycle(1'b1, {7'd0, 5'd0, 5'd0, 3'd0, 5'd0, OP_STORE}, 1'b0, 1'b0, acc);
        check_condition(acc && !stall, "dependent store was not dispatched");
        run_cycle(1'b0, '0, 1'b0, 1'b0, acc);
        report_test("dependent dispatch", mark);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // bound allows every instruction to wait out a gemm and a full arbitration round
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/dispatch_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_core_top (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            fetch_valid,
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    input  logic                            freeze,
    input  logic                            flush,
    output logic                            stall,
    output dispatch_pkg::issue_t            issue,
    output dispatch_pkg::wb_t               wb
);
    import dispatch_pkg::*;

    logic [N_FU-1:0] fu_busy;
    logic [N_FU-1:0] start;
    logic [N_FU-1:0] wb_req;
    logic [N_FU-1:0] grant;
    wb_t slot_dest;
    wb_t slot_info [N_FU];

    dispatch_stage u_stage (
        .CLK        (CLK),
        .nRST       (nRST),
        .fetch_valid(fetch_valid),
        .instr      (instr),
        .freeze     (freeze),
        .flush      (flush),
        .fu_busy    (fu_busy),
        .wb         (wb),
        .stall      (stall),
        .start      (start),
        .dest       (slot_dest),
        .issue      (issue)
    );

    // slot i is the unit named by fu_id_t value i
    for (genvar i = 0; i < N_FU; i++) begin : g_slot
        fu_slot #(.LATENCY(FU_LAT[i])) u_slot (
            .CLK    (CLK),
            .nRST   (nRST),
            .start  (start[i]),
            .dest   (slot_dest),
            .grant  (grant[i]),
            .busy   (fu_busy[i]),
            .wb_req (wb_req[i]),
            .wb_info(slot_info[i])
        );
    end

    wb_arbiter u_arb (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (wb_req),
        .info (slot_info),
        .grant(grant),
        .wb   (wb)
    );

endmodule

`default_nettype wire

// File: verilog/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    localparam int WORD_W  = 32;
    localparam int N_SREGS = 32;
    localparam int N_MREGS = 16;
    localparam int N_FU    = 5;

    // cycles from start to writeback request, per slot
    localparam int LAT_ALU    = 2;
    localparam int LAT_LDST   = 4;
    localparam int LAT_BRANCH = 1;
    localparam int LAT_MLDST  = 6;
    localparam int LAT_GEMM   = 8;

    // indexed by fu_id_t
    localparam int FU_LAT [N_FU] = '{LAT_ALU, LAT_LDST, LAT_BRANCH, LAT_MLDST, LAT_GEMM};

    typedef logic [4:0] regbits_t;
    typedef logic [3:0] matbits_t;
    typedef logic [1:0] tag_t;

    localparam tag_t TAG_READY = 2'd0;
    localparam tag_t TAG_EXEC  = 2'd1;
    localparam tag_t TAG_LOAD  = 2'd2;

    typedef enum logic [6:0] {
        OP_NOP    = 7'b0000000,
        OP_LOAD   = 7'b0000011,
        OP_MLOAD  = 7'b0000111,
        OP_ALUI   = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_MSTORE = 7'b0100111,
        OP_ALU    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_GEMM   = 7'b1110111
    } opcode_t;

    typedef enum logic [1:0] {
        FU_NONE_T,
        FU_S_T,
        FU_M_T,
        FU_G_T
    } fu_type_t;

    typedef enum logic [2:0] {
        FU_ALU    = 3'd0,
        FU_LDST   = 3'd1,
        FU_BRANCH = 3'd2,
        FU_MLDST  = 3'd3,
        FU_GEMM   = 3'd4
    } fu_id_t;

    typedef struct packed {
        fu_type_t   fu_type;
        fu_id_t     fu_id;
        logic       s_reg_write;
        logic       m_reg_write;
        logic       is_load;
        logic [11:0] imm;
    } decode_t;

    typedef struct packed {
        logic        valid;
        fu_id_t      fu_id;
        regbits_t    s_rd;
        matbits_t    m_rd;
        regbits_t    rs1;
        regbits_t    rs2;
        matbits_t    ms1;
        matbits_t    ms2;
        matbits_t    ms3;
        tag_t        t1;
        tag_t        t2;
        tag_t        t3;
        logic [11:0] imm;
    } issue_t;

    typedef struct packed {
        logic     valid;
        fu_id_t   fu_id;
        logic     s_rw_en;
        regbits_t s_rw;
        logic     m_rw_en;
        matbits_t m_rw;
    } wb_t;

endpackage

`default_nettype wire

// File: verilog/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            fetch_valid,
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    input  logic                            freeze,
    input  logic                            flush,
    input  logic [dispatch_pkg::N_FU-1:0]   fu_busy,
    input  dispatch_pkg::wb_t               wb,
    output logic                            stall,
    output logic [dispatch_pkg::N_FU-1:0]   start,
    output dispatch_pkg::wb_t               dest,
    output dispatch_pkg::issue_t            issue
);
    import dispatch_pkg::*;

    decode_t dec;
    regbits_t s_rd;
    regbits_t rs1;
    regbits_t rs2;
    matbits_t m_rd;
    matbits_t ms1;
    matbits_t ms2;
    matbits_t ms3;
    logic [N_SREGS-1:0] s_busy;
    tag_t s_tag [N_SREGS];
    logic [N_MREGS-1:0] m_busy;
    tag_t m_tag [N_MREGS];
    logic has_fu;
    logic struct_haz;
    logic waw_haz;
    logic accept;
    tag_t di_tag;
    issue_t next_issue;

    // fixed field positions, matrix loads reuse rs1/rs2 for the address
    assign s_rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign m_rd = instr[31:28];
    assign ms1 = instr[27:24];
    assign ms2 = instr[23:20];
    assign ms3 = instr[19:16];

    instr_decoder u_dec (
        .instr(instr),
        .dec  (dec)
    );

    assign has_fu = (dec.fu_type != FU_NONE_T);
    assign struct_haz = has_fu && fu_busy[dec.fu_id];

    always_comb begin
        waw_haz = 1'b0;
        if (dec.s_reg_write) begin
            waw_haz = s_busy[s_rd];
        end else if (dec.m_reg_write) begin
            waw_haz = m_busy[m_rd];
        end
    end

    assign stall = struct_haz | waw_haz;
    assign accept = fetch_valid & ~stall & ~freeze & ~flush;
    assign di_tag = dec.is_load ? TAG_LOAD : TAG_EXEC;

    reg_status_table #(.N_REGS(N_SREGS)) scalar_rst (
        .CLK     (CLK),
        .nRST    (nRST),
        .di_write(accept & dec.s_reg_write),
        .di_sel  (s_rd),
        .di_tag  (di_tag),
        .wb_write(wb.valid & wb.s_rw_en),
        .wb_sel  (wb.s_rw),
        .busy_vec(s_busy),
        .tag_vec (s_tag)
    );

    reg_status_table #(.N_REGS(N_MREGS)) matrix_rst (
        .CLK     (CLK),
        .nRST    (nRST),
        .di_write(accept & dec.m_reg_write),
        .di_sel  (m_rd),
        .di_tag  (di_tag),
        .wb_write(wb.valid & wb.m_rw_en),
        .wb_sel  (wb.m_rw),
        .busy_vec(m_busy),
        .tag_vec (m_tag)
    );

    // one-hot start, sampled by the slot on the accept edge
    always_comb begin
        start = '0;
        if (accept && has_fu) begin
            start[dec.fu_id] = 1'b1;
        end
    end

    // destination record handed to every slot, only the started one keeps it
    always_comb begin
        dest = '0;
        dest.valid = has_fu;
        dest.fu_id = dec.fu_id;
        dest.s_rw_en = dec.s_reg_write;
        dest.s_rw = s_rd;
        dest.m_rw_en = dec.m_reg_write;
        dest.m_rw = m_rd;
    end

    // operand tags come from the tables before this instruction's own write
    always_comb begin
        next_issue = '0;
        next_issue.valid = has_fu;
        next_issue.fu_id = dec.fu_id;
        next_issue.s_rd = s_rd;
        next_issue.m_rd = m_rd;
        next_issue.rs1 = rs1;
        next_issue.rs2 = rs2;
        next_issue.ms1 = ms1;
        next_issue.ms2 = ms2;
        next_issue.ms3 = ms3;
        next_issue.imm = dec.imm;
        case (dec.fu_type)
            FU_S_T, FU_M_T: begin
                next_issue.t1 = s_tag[rs1];
                next_issue.t2 = s_tag[rs2];
            end
            FU_G_T: begin
                next_issue.t1 = m_tag[ms1];
                next_issue.t2 = m_tag[ms2];
                next_issue.t3 = m_tag[ms3];
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue <= '0;
        end else if (flush) begin
            issue <= '0;
        end else if (!freeze) begin
            // a stall or an empty fetch slot leaves a bubble
            issue <= accept ? next_issue : '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fu_slot.sv
`timescale 1ns/1ps
`default_nettype none

module fu_slot #(
    parameter int LATENCY = 1
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              start,
    input  dispatch_pkg::wb_t dest,
    input  logic              grant,
    output logic              busy,
    output logic              wb_req,
    output dispatch_pkg::wb_t wb_info
);
    logic [$clog2(LATENCY+1)-1:0] count;
    dispatch_pkg::wb_t dest_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy <= 1'b1;
            count <= LATENCY[$clog2(LATENCY+1)-1:0];
        end else if (busy) begin
            // stays busy while waiting for the bus, this stalls new work here
            if (grant) begin
                busy <= 1'b0;
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            dest_q <= dest;
        end
    end

    assign wb_req = busy && (count == '0);

    always_comb begin
        wb_info = dest_q;
        wb_info.valid = wb_req;
    end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    output dispatch_pkg::decode_t           dec
);
    import dispatch_pkg::*;

    opcode_t op;

    assign op = opcode_t'(instr[6:0]);

    always_comb begin
        dec = '0;
        dec.fu_type = FU_NONE_T;
        dec.fu_id = FU_ALU;
        case (op)
            OP_ALU: begin
                dec.fu_type = FU_S_T;
                dec.s_reg_write = 1'b1;
            end
            OP_ALUI: begin
                dec.fu_type = FU_S_T;
                dec.s_reg_write = 1'b1;
                dec.imm = instr[31:20];
            end
            OP_LOAD: begin
                dec.fu_type = FU_S_T;
                dec.fu_id = FU_LDST;
                dec.s_reg_write = 1'b1;
                dec.is_load = 1'b1;
                dec.imm = instr[31:20];
            end
            OP_STORE: begin
                dec.fu_type = FU_S_T;
                dec.fu_id = FU_LDST;
                // store offset is split around the rd field
                dec.imm = {instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                dec.fu_type = FU_S_T;
                dec.fu_id = FU_BRANCH;
                dec.imm = {instr[31], instr[7], instr[30:25], instr[11:8]};
            end
            OP_MLOAD: begin
                dec.fu_type = FU_M_T;
                dec.fu_id = FU_MLDST;
                dec.m_reg_write = 1'b1;
                dec.is_load = 1'b1;
                // short signed stride offset for matrix rows
                dec.imm = {{9{instr[14]}}, instr[14:12]};
            end
            OP_MSTORE: begin
                dec.fu_type = FU_M_T;
                dec.fu_id = FU_MLDST;
                dec.imm = {{9{instr[14]}}, instr[14:12]};
            end
            OP_GEMM: begin
                dec.fu_type = FU_G_T;
                dec.fu_id = FU_GEMM;
                dec.m_reg_write = 1'b1;
            end
            // no unit and no write
            OP_NOP: ;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/reg_status_table.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_table #(
    parameter int N_REGS = 32
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      di_write,
    input  logic [$clog2(N_REGS)-1:0] di_sel,
    input  dispatch_pkg::tag_t        di_tag,
    input  logic                      wb_write,
    input  logic [$clog2(N_REGS)-1:0] wb_sel,
    output logic [N_REGS-1:0]         busy_vec,
    output dispatch_pkg::tag_t        tag_vec [N_REGS]
);
    import dispatch_pkg::*;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_vec <= '0;
            for (int i = 0; i < N_REGS; i++) begin
                tag_vec[i] <= TAG_READY;
            end
        end else begin
            // commit frees the register
            if (wb_write) begin
                busy_vec[wb_sel] <= 1'b0;
                tag_vec[wb_sel] <= TAG_READY;
            end
            // never the same index as the clear, waw stall keeps them apart
            if (di_write) begin
                busy_vec[di_sel] <= 1'b1;
                tag_vec[di_sel] <= di_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic [dispatch_pkg::N_FU-1:0] req,
    input  dispatch_pkg::wb_t             info [dispatch_pkg::N_FU],
    output logic [dispatch_pkg::N_FU-1:0] grant,
    output dispatch_pkg::wb_t             wb
);
    import dispatch_pkg::*;

    // highest priority position, one past the last winner
    fu_id_t ptr;
    fu_id_t win;
    logic found;

    always_comb begin
        int idx;
        grant = '0;
        win = ptr;
        found = 1'b0;
        for (int i = 0; i < N_FU; i++) begin
            idx = (int'(ptr) + i) % N_FU;
            if (!found && req[idx]) begin
                found = 1'b1;
                win = fu_id_t'(idx);
            end
        end
        if (found) begin
            grant[win] = 1'b1;
        end
    end

    assign wb = found ? info[win] : '0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ptr <= FU_ALU;
        end else if (found) begin
            if (win == FU_GEMM) begin
                ptr <= FU_ALU;
            end else begin
                ptr <= fu_id_t'(win + 3'd1);
            end
        end
    end

endmodule

`default_nettype wire
